/* hdl/lsu_pkg.sv */
// Shared constants and types for the RV32 load/store unit with data PMP.
// Every design file refers to these by scoped names through lsu_pkg::.

package lsu_pkg;

    // ----------------------------------------------------------
    // data path
    // ----------------------------------------------------------
    localparam int xlen_c  = 32;         // data path width
    localparam int ben_w_c = xlen_c / 8; // one enable per byte

    // ----------------------------------------------------------
    // physical memory protection
    // ----------------------------------------------------------
    localparam int pmp_regions_c = 4;  // implemented regions
    localparam int pmp_lsb_c     = 2;  // 4-byte granularity
    localparam int pmp_addr_w_c  = 34; // pmpaddr entry width

    // bit positions inside one pmpcfg byte
    localparam int pmp_cfg_r_c  = 0; // read permit
    localparam int pmp_cfg_w_c  = 1; // write permit
    localparam int pmp_cfg_al_c = 3; // mode field low bit
    localparam int pmp_cfg_ah_c = 4; // mode field high bit
    localparam int pmp_cfg_l_c  = 7; // lock bit

    // ----------------------------------------------------------
    // enums
    // ----------------------------------------------------------
    // access size from funct3[1:0]
    typedef enum logic [1:0] {
        size_byte = 2'b00, // lb / lbu / sb
        size_half = 2'b01, // lh / lhu / sh
        size_word = 2'b10  // lw / sw
    } access_size_e;

    // effective privilege of the data access
    typedef enum logic {
        priv_user    = 1'b0,
        priv_machine = 1'b1
    } priv_mode_e;

    // pmpcfg address matching mode
    typedef enum logic [1:0] {
        pmp_off = 2'b00, // region disabled
        pmp_tor = 2'b01  // top of range
    } pmp_mode_e;         // NA4 / NAPOT encodings treated as off

endpackage

/* hdl/lsu_req_if.sv */
// Registered request of the current data access.
// Written by the request stage, read by the access arbiter and the
// load aligner. Fields load on mo_we_i and hold otherwise.

`timescale 1ns/1ps

interface lsu_req_if;

    logic [lsu_pkg::xlen_c-1:0] mar;           // memory address register
    logic                       misaligned;    // address violates size alignment
    lsu_pkg::access_size_e      size;          // byte / half / word
    logic                       load_unsigned; // funct3[2] of the access
    logic                       is_store;      // direction of the access

    // request registers own all fields
    modport mp_producer (
        output mar,
        output misaligned,
        output size,
        output load_unsigned,
        output is_store
    );

    // arbiter only needs direction and alignment
    modport mp_arbiter (
        input misaligned,
        input is_store
    );

    // load formatting
    modport mp_align (
        input mar,
        input size,
        input load_unsigned
    );

endinterface

/* hdl/lsu_pmp_check.sv */
// PMP check of the data address in top-of-range mode.
// Purely combinational; the arbiter registers both fault flags.
// The lowest-numbered matching region decides, debug mode overrides.

`timescale 1ns/1ps

module lsu_pmp_check (
    input  logic [lsu_pkg::xlen_c-1:0]       addr_i,     // data access address
    input  lsu_pkg::priv_mode_e              bus_priv_i, // effective privilege
    input  logic                             debug_i,    // debug mode, no checks
    input  logic [lsu_pkg::pmp_addr_w_c-1:0] pmp_addr_i [lsu_pkg::pmp_regions_c],
    input  logic [7:0]                       pmp_ctrl_i [lsu_pkg::pmp_regions_c],
    output logic                             ld_fault_o, // load not permitted
    output logic                             st_fault_o  // store not permitted
);

    logic [lsu_pkg::pmp_regions_c-1:0] cmp_lt;  // addr below region bound
    logic [lsu_pkg::pmp_regions_c-1:0] match;   // addr inside region
    logic [lsu_pkg::pmp_regions_c-1:0] perm_rd; // read allowed in region
    logic [lsu_pkg::pmp_regions_c-1:0] perm_wr; // write allowed in region
    logic                              ld_fault;
    logic                              st_fault;

    // ----------------------------------------------------------
    // region match
    // ----------------------------------------------------------
    // one comparator per bound; base of region r is bound r-1
    always_comb begin
        for (int r = 0; r < lsu_pkg::pmp_regions_c; r++) begin
            cmp_lt[r] = addr_i[lsu_pkg::xlen_c-1:lsu_pkg::pmp_lsb_c] <
                        pmp_addr_i[r][lsu_pkg::xlen_c-1:lsu_pkg::pmp_lsb_c];
        end
    end

    always_comb begin
        for (int r = 0; r < lsu_pkg::pmp_regions_c; r++) begin
            if (lsu_pkg::pmp_mode_e'(pmp_ctrl_i[r][lsu_pkg::pmp_cfg_ah_c:lsu_pkg::pmp_cfg_al_c])
                    == lsu_pkg::pmp_tor) begin
                if (r == 0) begin
                    match[r] = cmp_lt[r]; // base is zero
                end else begin
                    match[r] = ~cmp_lt[r-1] & cmp_lt[r]; // prev bound <= addr < bound
                end
            end else begin
                match[r] = 1'b0; // off, NA4 and NAPOT never match
            end
        end
    end

    // ----------------------------------------------------------
    // permissions
    // ----------------------------------------------------------
    always_comb begin
        for (int r = 0; r < lsu_pkg::pmp_regions_c; r++) begin
            if (bus_priv_i == lsu_pkg::priv_machine) begin
                // machine mode bypasses unlocked entries
                perm_rd[r] = ~pmp_ctrl_i[r][lsu_pkg::pmp_cfg_l_c] |
                             pmp_ctrl_i[r][lsu_pkg::pmp_cfg_r_c];
                perm_wr[r] = ~pmp_ctrl_i[r][lsu_pkg::pmp_cfg_l_c] |
                             pmp_ctrl_i[r][lsu_pkg::pmp_cfg_w_c];
            end else begin
                perm_rd[r] = pmp_ctrl_i[r][lsu_pkg::pmp_cfg_r_c]; // user always checked
                perm_wr[r] = pmp_ctrl_i[r][lsu_pkg::pmp_cfg_w_c];
            end
        end
    end

    // ----------------------------------------------------------
    // priority chain
    // ----------------------------------------------------------
    // walk from the highest region down so region 0 wins
    always_comb begin
        ld_fault = (bus_priv_i != lsu_pkg::priv_machine); // no match faults in user mode
        st_fault = (bus_priv_i != lsu_pkg::priv_machine);
        for (int r = lsu_pkg::pmp_regions_c-1; r >= 0; r--) begin
            if (match[r]) begin
                ld_fault = ~perm_rd[r];
                st_fault = ~perm_wr[r];
            end
        end
    end

    assign ld_fault_o = ld_fault & ~debug_i; // debug mode never faults
    assign st_fault_o = st_fault & ~debug_i;

endmodule

/* hdl/lsu_request.sv */
// Request stage of the load/store unit.
// Latches address and access type on mo_we_i, checks alignment, and
// prepares replicated write data with matching byte enables.

`timescale 1ns/1ps

module lsu_request (
    input  logic                        clk_i,
    input  logic                        mo_we_i,    // latch new access
    input  logic [2:0]                  funct3_i,   // size and unsigned flag
    input  logic                        is_store_i, // store when high
    input  logic [lsu_pkg::xlen_c-1:0]  addr_i,     // ALU result
    input  logic [lsu_pkg::xlen_c-1:0]  wdata_i,    // rs2 value
    lsu_req_if.mp_producer              req,
    output logic [lsu_pkg::xlen_c-1:0]  d_bus_wdata_o,
    output logic [lsu_pkg::ben_w_c-1:0] d_bus_ben_o
);

    lsu_pkg::access_size_e       size_nxt;  // decoded size
    logic                        misal_nxt; // alignment check on addr_i
    logic [lsu_pkg::xlen_c-1:0]  wdata_nxt;
    logic [lsu_pkg::ben_w_c-1:0] ben_nxt;

    // ----------------------------------------------------------
    // decode and alignment
    // ----------------------------------------------------------
    always_comb begin
        case (funct3_i[1:0])
            2'b00:   size_nxt = lsu_pkg::size_byte;
            2'b01:   size_nxt = lsu_pkg::size_half;
            default: size_nxt = lsu_pkg::size_word; // 2'b11 has no RV32 meaning
        endcase
    end

    always_comb begin
        case (size_nxt)
            lsu_pkg::size_half: misal_nxt = addr_i[0];             // needs even address
            lsu_pkg::size_word: misal_nxt = addr_i[1] | addr_i[0]; // needs 4-byte boundary
            default:            misal_nxt = 1'b0;                  // bytes always fit
        endcase
    end

    // ----------------------------------------------------------
    // write data and byte enables
    // ----------------------------------------------------------
    always_comb begin
        case (size_nxt)
            lsu_pkg::size_byte: begin
                wdata_nxt = {(lsu_pkg::xlen_c/8){wdata_i[7:0]}}; // byte in every lane
                ben_nxt   = {{(lsu_pkg::ben_w_c-1){1'b0}}, 1'b1} << addr_i[1:0];
            end
            lsu_pkg::size_half: begin
                wdata_nxt = {(lsu_pkg::xlen_c/16){wdata_i[15:0]}}; // both halves
                ben_nxt   = addr_i[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata_nxt = wdata_i;  // word as is
                ben_nxt   = '1;       // all lanes
            end
        endcase
    end

    // ----------------------------------------------------------
    // request registers
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (mo_we_i) begin
            req.mar           <= addr_i;
            req.misaligned    <= misal_nxt;
            req.size          <= size_nxt;
            req.load_unsigned <= funct3_i[2]; // lbu / lhu
            req.is_store      <= is_store_i;
            d_bus_wdata_o     <= wdata_nxt;
            d_bus_ben_o       <= ben_nxt;
        end
    end

endmodule

/* hdl/lsu_access_arbiter.sv */
// Access arbiter of the load/store unit.
// Tracks the one access in flight, collects bus errors and registered
// PMP faults, and drives bus strobes and the trap flags by direction.

`timescale 1ns/1ps

module lsu_access_arbiter (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic bus_req_i,   // start pulse
    input  logic trap_i,      // abort pending access
    input  logic ld_fault_i,  // combinational PMP load fault
    input  logic st_fault_i,  // combinational PMP store fault
    input  logic d_bus_ack_i,
    input  logic d_bus_err_i,
    lsu_req_if.mp_arbiter req,
    output logic d_wait_o,
    output logic ma_load_o,
    output logic ma_store_o,
    output logic be_load_o,
    output logic be_store_o,
    output logic d_bus_we_o,
    output logic d_bus_re_o
);

    logic pend;      // access in flight
    logic err;       // sticky error of this access
    logic pmp_r_err; // registered load fault
    logic pmp_w_err; // registered store fault
    logic pmp_err;   // fault matching the direction

    assign pmp_err = req.is_store ? pmp_w_err : pmp_r_err;

    // ----------------------------------------------------------
    // pending state and error accumulation
    // ----------------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pend      <= 1'b0;
            err       <= 1'b0;
            pmp_r_err <= 1'b0;
            pmp_w_err <= 1'b0;
        end else begin
            pmp_r_err <= ld_fault_i; // sampled every cycle
            pmp_w_err <= st_fault_i;
            if (!pend) begin
                err <= 1'b0; // fresh start for next access
                if (bus_req_i) begin
                    pend <= 1'b1;
                end
            end else begin
                if (d_bus_err_i || pmp_err) begin
                    err <= 1'b1;
                end
                if (d_bus_ack_i || trap_i) begin
                    pend <= 1'b0; // normal end or trap entry
                end
            end
        end
    end

    assign d_wait_o = ~d_bus_ack_i; // stall until memory answers

    // flags only while the access is pending
    assign ma_load_o  = pend & ~req.is_store & req.misaligned;
    assign ma_store_o = pend &  req.is_store & req.misaligned;
    assign be_load_o  = pend & ~req.is_store & err;
    assign be_store_o = pend &  req.is_store & err;

    // strobes only in the request cycle, none for bad accesses
    assign d_bus_we_o = bus_req_i &  req.is_store & ~req.misaligned & ~pmp_w_err;
    assign d_bus_re_o = bus_req_i & ~req.is_store & ~req.misaligned & ~pmp_r_err;

endmodule

/* hdl/lsu_load_align.sv */
// Load data formatting.
// Picks the addressed byte or half-word from the bus word and extends it
// with zeros or the sign bit; the result is registered every cycle.

`timescale 1ns/1ps

module lsu_load_align (
    input  logic                       clk_i,
    input  logic [lsu_pkg::xlen_c-1:0] d_bus_rdata_i, // raw bus word
    lsu_req_if.mp_align                req,
    output logic [lsu_pkg::xlen_c-1:0] rdata_o        // formatted load result
);

    logic [7:0]                 sel_byte; // addressed byte lane
    logic [15:0]                sel_half; // addressed half-word
    logic                       sext_b;   // fill bit for byte loads
    logic                       sext_h;   // fill bit for half loads
    logic [lsu_pkg::xlen_c-1:0] rdata_nxt;

    // ----------------------------------------------------------
    // lane select
    // ----------------------------------------------------------
    assign sel_byte = d_bus_rdata_i[req.mar[1:0]*8 +: 8];
    assign sel_half = req.mar[1] ? d_bus_rdata_i[31:16] : d_bus_rdata_i[15:0];

    assign sext_b = ~req.load_unsigned & sel_byte[7];  // lb sign
    assign sext_h = ~req.load_unsigned & sel_half[15]; // lh sign

    // ----------------------------------------------------------
    // extension
    // ----------------------------------------------------------
    always_comb begin
        case (req.size)
            lsu_pkg::size_byte: begin
                rdata_nxt = {{(lsu_pkg::xlen_c-8){sext_b}}, sel_byte};
            end
            lsu_pkg::size_half: begin
                rdata_nxt = {{(lsu_pkg::xlen_c-16){sext_h}}, sel_half};
            end
            default: begin
                rdata_nxt = d_bus_rdata_i; // word passes through
            end
        endcase
    end

    // valid the cycle after ack
    always_ff @(posedge clk_i) begin
        rdata_o <= rdata_nxt;
    end

endmodule

/* hdl/lsu_top.sv */
// Top level of the RV32 data load/store unit with PMP.
// Connects the request stage, PMP check, access arbiter and load aligner.
// The caller holds addr_i stable from mo_we_i until bus_req_i.

`timescale 1ns/1ps

module lsu_top (
    input  logic                             clk_i,
    input  logic                             rstn_i,
    // control from the core
    input  logic                             mo_we_i,    // latch address and type
    input  logic [2:0]                       funct3_i,
    input  logic                             is_store_i,
    input  logic                             bus_req_i,  // start access
    input  logic                             trap_i,     // abort access
    input  logic                             debug_i,    // debug mode
    input  lsu_pkg::priv_mode_e              bus_priv_i, // effective privilege
    // data path
    input  logic [lsu_pkg::xlen_c-1:0]       addr_i,
    input  logic [lsu_pkg::xlen_c-1:0]       wdata_i,
    output logic [lsu_pkg::xlen_c-1:0]       rdata_o,
    output logic [lsu_pkg::xlen_c-1:0]       mar_o,      // for mtval
    output logic                             d_wait_o,
    output logic                             ma_load_o,
    output logic                             ma_store_o,
    output logic                             be_load_o,
    output logic                             be_store_o,
    // PMP tables
    input  logic [lsu_pkg::pmp_addr_w_c-1:0] pmp_addr_i [lsu_pkg::pmp_regions_c],
    input  logic [7:0]                       pmp_ctrl_i [lsu_pkg::pmp_regions_c],
    // data bus
    output logic [lsu_pkg::xlen_c-1:0]       d_bus_addr_o,
    input  logic [lsu_pkg::xlen_c-1:0]       d_bus_rdata_i,
    output logic [lsu_pkg::xlen_c-1:0]       d_bus_wdata_o,
    output logic [lsu_pkg::ben_w_c-1:0]      d_bus_ben_o,
    output logic                             d_bus_we_o,
    output logic                             d_bus_re_o,
    input  logic                             d_bus_ack_i,
    input  logic                             d_bus_err_i
);

    lsu_req_if req_if ();

    logic ld_fault; // PMP check to arbiter
    logic st_fault;

    assign mar_o        = req_if.mar;
    assign d_bus_addr_o = req_if.mar; // bus address straight from mar

    lsu_request u_request (
        .clk_i         (clk_i),
        .mo_we_i       (mo_we_i),
        .funct3_i      (funct3_i),
        .is_store_i    (is_store_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .req           (req_if.mp_producer),
        .d_bus_wdata_o (d_bus_wdata_o),
        .d_bus_ben_o   (d_bus_ben_o)
    );

    lsu_pmp_check u_pmp_check (
        .addr_i     (addr_i),
        .bus_priv_i (bus_priv_i),
        .debug_i    (debug_i),
        .pmp_addr_i (pmp_addr_i),
        .pmp_ctrl_i (pmp_ctrl_i),
        .ld_fault_o (ld_fault),
        .st_fault_o (st_fault)
    );

    lsu_access_arbiter u_arbiter (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .bus_req_i   (bus_req_i),
        .trap_i      (trap_i),
        .ld_fault_i  (ld_fault),
        .st_fault_i  (st_fault),
        .d_bus_ack_i (d_bus_ack_i),
        .d_bus_err_i (d_bus_err_i),
        .req         (req_if.mp_arbiter),
        .d_wait_o    (d_wait_o),
        .ma_load_o   (ma_load_o),
        .ma_store_o  (ma_store_o),
        .be_load_o   (be_load_o),
        .be_store_o  (be_store_o),
        .d_bus_we_o  (d_bus_we_o),
        .d_bus_re_o  (d_bus_re_o)
    );

    lsu_load_align u_load_align (
        .clk_i         (clk_i),
        .d_bus_rdata_i (d_bus_rdata_i),
        .req           (req_if.mp_align),
        .rdata_o       (rdata_o)
    );

endmodule

/* verification/lsu_checker.sv */
// Checker beside the DUT in the load/store unit testbench.
// Samples DUT outputs on the falling edge, compares them with the
// expected values of the current access and counts errors.

`timescale 1ns/1ps

module lsu_checker (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic [31:0] mar_i,
    input  logic [31:0] d_bus_addr_i,
    input  logic [31:0] d_bus_wdata_i,
    input  logic [31:0] rdata_i,
    input  logic [3:0]  d_bus_ben_i,
    input  logic        d_bus_we_i,
    input  logic        d_bus_re_i,
    input  logic        ack_i,        // memory acknowledge as driven
    input  logic        d_wait_i,
    input  logic        ma_load_i,
    input  logic        ma_store_i,
    input  logic        be_load_i,
    input  logic        be_store_i,
    input  logic        busy_i,       // access in flight
    input  logic        chk_req_i,    // request cycle
    input  logic        chk_end_i,    // last pending cycle
    input  logic        chk_rdata_i,  // cycle after ack of a load
    input  logic [31:0] exp_addr_i,
    input  logic [31:0] exp_wdata_i,
    input  logic [31:0] exp_rdata_i,
    input  logic [3:0]  exp_ben_i,
    input  logic [5:0]  exp_flags_i,  // re we ma_ld ma_st be_ld be_st
    output logic [31:0] err_cnt_o
);

    int errors = 0;

    assign err_cnt_o = errors;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // ------------------------------------------------------------
    // falling-edge sampling
    // ------------------------------------------------------------
    always @(negedge clk_i) begin
        logic wait_exp;
        wait_exp = ~ack_i;
        compare("d_wait_o", d_wait_i, wait_exp); // every cycle
        if (!chk_req_i) begin // strobes only in the request cycle
            compare("d_bus_re_o", d_bus_re_i, 1'b0);
            compare("d_bus_we_o", d_bus_we_i, 1'b0);
        end
        if (!rstn_i || !busy_i) begin // nothing pending, incl. reset
            compare("ma_load_o", ma_load_i, 1'b0);
            compare("ma_store_o", ma_store_i, 1'b0);
            compare("be_load_o", be_load_i, 1'b0);
            compare("be_store_o", be_store_i, 1'b0);
        end
        if (chk_req_i) begin
            compare("mar_o", mar_i, exp_addr_i);
            compare("d_bus_addr_o", d_bus_addr_i, exp_addr_i);
            compare("d_bus_ben_o", d_bus_ben_i, exp_ben_i);
            compare("d_bus_wdata_o", d_bus_wdata_i, exp_wdata_i);
            compare("d_bus_re_o", d_bus_re_i, exp_flags_i[5]);
            compare("d_bus_we_o", d_bus_we_i, exp_flags_i[4]);
        end
        if (chk_end_i) begin
            compare("ma_load_o", ma_load_i, exp_flags_i[3]);
            compare("ma_store_o", ma_store_i, exp_flags_i[2]);
            compare("be_load_o", be_load_i, exp_flags_i[1]);
            compare("be_store_o", be_store_i, exp_flags_i[0]);
        end
        if (chk_rdata_i) begin
            compare("rdata_o", rdata_i, exp_rdata_i);
        end
    end

endmodule

/* verification/lsu_tb.sv */
// Testbench for the RV32 data load/store unit with PMP.
// Reads one access per line from the stimulus file, acts as core and memory,
// and leaves all comparing to the checker beside the DUT.

`timescale 1ns/1ps

module lsu_tb;

    localparam int    clk_period_c = 100;                          // ns
    localparam int    drive_dly_c  = 1;                            // after rising edge
    localparam int    seed_init_c  = 26270;
    localparam string stim_file_c  = "verification/lsu_input.dat";

    logic clk, rstn, mo_we, is_store, bus_req, trap, debug, ack, berr;
    logic d_wait, ma_load, ma_store, be_load, be_store, bus_we, bus_re;
    logic [2:0]  funct3;
    logic [3:0]  ben;
    logic [31:0] addr, wdata, rdata, mar, bus_addr, bus_rdata, bus_wdata;
    lsu_pkg::priv_mode_e bus_priv;
    logic [lsu_pkg::pmp_addr_w_c-1:0] pmp_addr [lsu_pkg::pmp_regions_c];
    logic [7:0]                       pmp_ctrl [lsu_pkg::pmp_regions_c];

    // expected side, handed to the checker
    logic        busy, chk_req, chk_end, chk_rdata;
    logic [31:0] exp_addr, exp_wdata, exp_rdata, err_chk;
    logic [3:0]  exp_ben;
    logic [5:0]  exp_flags;

    int    err_tb;
    int    seed;
    int    acc_cnt;
    logic  loaded;
    string acc_q[$]; // raw stimulus lines

    initial begin
        clk = 1'b0;
        forever #(clk_period_c/2) clk = ~clk;
    end

    lsu_top dut_i (
        .clk_i(clk), .rstn_i(rstn), .mo_we_i(mo_we), .funct3_i(funct3),
        .is_store_i(is_store), .bus_req_i(bus_req), .trap_i(trap), .debug_i(debug),
        .bus_priv_i(bus_priv), .addr_i(addr), .wdata_i(wdata), .rdata_o(rdata),
        .mar_o(mar), .d_wait_o(d_wait), .ma_load_o(ma_load), .ma_store_o(ma_store),
        .be_load_o(be_load), .be_store_o(be_store), .pmp_addr_i(pmp_addr),
        .pmp_ctrl_i(pmp_ctrl), .d_bus_addr_o(bus_addr), .d_bus_rdata_i(bus_rdata),
        .d_bus_wdata_o(bus_wdata), .d_bus_ben_o(ben), .d_bus_we_o(bus_we),
        .d_bus_re_o(bus_re), .d_bus_ack_i(ack), .d_bus_err_i(berr)
    );

    lsu_checker u_checker (
        .clk_i(clk), .rstn_i(rstn), .mar_i(mar), .d_bus_addr_i(bus_addr),
        .d_bus_wdata_i(bus_wdata), .rdata_i(rdata), .d_bus_ben_i(ben),
        .d_bus_we_i(bus_we), .d_bus_re_i(bus_re), .ack_i(ack), .d_wait_i(d_wait),
        .ma_load_i(ma_load), .ma_store_i(ma_store), .be_load_i(be_load),
        .be_store_i(be_store), .busy_i(busy), .chk_req_i(chk_req), .chk_end_i(chk_end),
        .chk_rdata_i(chk_rdata), .exp_addr_i(exp_addr), .exp_wdata_i(exp_wdata),
        .exp_rdata_i(exp_rdata), .exp_ben_i(exp_ben), .exp_flags_i(exp_flags),
        .err_cnt_o(err_chk)
    );

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #drive_dly_c;
        end
    endtask

    task automatic load_stimulus();
        int    fd;
        int    rc;
        string line;
        fd = $fopen(stim_file_c, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s", stim_file_c);
            err_tb++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (rc > 0 && line.len() > 2 && line.substr(0, 1) != "//") begin
                    acc_q.push_back(line); // skip column notes and blank lines
                end
            end
            $fclose(fd);
        end
    endtask

    // one access: address phase, request cycle, pending cycles, rdata cycle
    task automatic run_access(input string line);
        logic [31:0] st, f3, pr, dbg, a, wd, lat, er, rd, eb, ewd, erd, efl;
        int          n;
        int          k;
        logic        strobe;
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                    st, f3, pr, dbg, a, wd, lat, er, rd, eb, ewd, erd, efl);
        if (n != 13) begin
            $display("malformed stimulus line, %0d fields: %s", n, line);
            err_tb++;
        end else begin
            mo_we    = 1'b1;
            funct3   = f3[2:0];
            is_store = st[0];
            bus_priv = lsu_pkg::priv_mode_e'(pr[0]);
            debug    = dbg[0];
            addr     = a;
            wdata    = wd;
            bus_rdata = '0;       // no read data before ack
            exp_addr  = a;
            exp_wdata = ewd;
            exp_rdata = erd;
            exp_ben   = eb[3:0];
            exp_flags = efl[5:0];
            wait_cycles(1);
            mo_we   = 1'b0;       // request cycle
            bus_req = 1'b1;
            busy    = 1'b1;
            chk_req = 1'b1;
            @(negedge clk);
            strobe = bus_re | bus_we; // memory only answers a real strobe
            wait_cycles(1);
            bus_req = 1'b0;
            chk_req = 1'b0;
            for (k = 1; k <= lat; k++) begin
                berr = er[0] && (k == 1);
                if (k == lat) begin
                    ack       = strobe;
                    trap      = ~strobe; // core traps on a flagged access
                    chk_end   = 1'b1;
                    bus_rdata = rd;      // read data valid with ack
                end
                wait_cycles(1);
            end
            ack       = 1'b0;
            berr      = 1'b0;
            trap      = 1'b0;
            chk_end   = 1'b0;
            busy      = 1'b0;
            bus_rdata = '0;
            chk_rdata = strobe & ~st[0];
            wait_cycles(1);
            chk_rdata = 1'b0;
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        seed = seed_init_c;
        {rstn, mo_we, is_store, bus_req, trap, debug, ack, berr} = '0;
        {busy, chk_req, chk_end, chk_rdata} = '0;
        funct3    = 3'd0;
        bus_priv  = lsu_pkg::priv_user;
        {addr, wdata, bus_rdata, exp_addr, exp_wdata, exp_rdata} = '0;
        exp_ben   = 4'h0;
        exp_flags = 6'h00;
        err_tb    = 0;
        loaded    = 1'b0;
        pmp_addr[0] = 'h100;  // TOR, locked, read only
        pmp_ctrl[0] = 8'h89;
        pmp_addr[1] = 'h1000; // TOR, read and write
        pmp_ctrl[1] = 8'h0b;
        pmp_addr[2] = '0;     // off
        pmp_ctrl[2] = 8'h00;
        pmp_addr[3] = '0;
        pmp_ctrl[3] = 8'h00;
        load_stimulus();
        acc_cnt = acc_q.size();
        if (acc_cnt == 0) begin
            $display("no accesses found in the stimulus file");
            err_tb++;
        end
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        #drive_dly_c;
        rstn = 1'b1;
        foreach (acc_q[i]) begin
            wait_cycles($unsigned($random(seed)) % 4); // idle gap
            run_access(acc_q[i]);
        end
        wait_cycles(4);
        $display("run done: %0d accesses, checker errors %0d, testbench errors %0d",
                 acc_cnt, err_chk, err_tb);
        if (err_chk == 0 && err_tb == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // about 12 cycles per access at most, so 20 leaves a wide margin
    initial begin
        wait (loaded);
        #((acc_cnt * 20 + 10) * clk_period_c);
        $display("timeout: run did not finish within %0d ns",
                 (acc_cnt * 20 + 10) * clk_period_c);
        $display("run done: %0d accesses, checker errors %0d, testbench errors %0d",
                 acc_cnt, err_chk, err_tb);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* verification/lsu_input.dat */
// store funct3 priv debug addr wdata latency err rdata, then expected ben wdata rdata flags
// flags in hex: bit5 re, bit4 we, bit3 ma_load, bit2 ma_store, bit1 be_load, bit0 be_store
1 0 0 0 00000200 11223344 2 0 00000000 1 44444444 00000000 10
1 0 0 0 00000201 a5a5a5c3 3 0 00000000 2 c3c3c3c3 00000000 10
1 0 0 0 00000202 0000007e 2 0 00000000 4 7e7e7e7e 00000000 10
1 0 0 0 00000203 deadbeef 4 0 00000000 8 efefefef 00000000 10
1 1 0 0 00000204 12345678 2 0 00000000 3 56785678 00000000 10
1 1 0 0 00000206 cafebabe 3 0 00000000 c babebabe 00000000 10
1 2 0 0 00000208 89abcdef 2 0 00000000 f 89abcdef 00000000 10
1 2 1 0 00002000 01020304 2 0 00000000 f 01020304 00000000 10
0 0 0 0 00000300 00000000 2 0 8899aa80 1 00000000 ffffff80 20
0 0 0 0 00000301 00000000 2 0 8899aa80 2 00000000 ffffffaa 20
0 4 0 0 00000302 00000000 3 0 8899aa80 4 00000000 00000099 20
0 0 0 0 00000303 00000000 2 0 7f001122 8 00000000 0000007f 20
0 4 0 0 00000303 00000000 2 0 f0001122 8 00000000 000000f0 20
0 1 0 0 00000304 00000000 2 0 1234f00d 3 00000000 fffff00d 20
0 1 0 0 00000306 00000000 4 0 7fff8000 c 00000000 00007fff 20
0 5 0 0 00000306 00000000 2 0 80010000 c 00000000 00008001 20
0 5 0 0 00000304 00000000 2 0 0000abcd 3 00000000 0000abcd 20
0 2 0 0 00000308 00000000 2 0 deadbeef f 00000000 deadbeef 20
0 2 0 0 0000030c 00000000 5 0 13579bdf f 00000000 13579bdf 20
1 1 0 0 00000401 0000beef 2 0 00000000 3 beefbeef 00000000 04
1 2 0 0 00000402 11111111 3 0 00000000 f 11111111 00000000 04
0 1 0 0 00000403 00000000 2 0 00000000 c 00000000 00000000 08
0 2 0 0 00000401 00000000 2 0 00000000 f 00000000 00000000 08
1 2 0 0 00000040 55667788 2 0 00000000 f 55667788 00000000 01
1 0 1 0 00000040 000000ab 2 0 00000000 1 abababab 00000000 01
0 2 0 0 00000040 00000000 2 0 00c0ffee f 00000000 00c0ffee 20
0 2 1 0 00000044 00000000 3 0 0badf00d f 00000000 0badf00d 20
0 2 0 0 00001000 00000000 2 0 00000000 f 00000000 00000000 02
1 2 0 0 00002004 00000000 2 0 00000000 f 00000000 00000000 01
1 2 0 1 00000040 76543210 2 0 00000000 f 76543210 00000000 10
0 2 0 1 00001000 00000000 2 0 600dcafe f 00000000 600dcafe 20
1 1 1 1 00000042 0000a1b2 2 0 00000000 c a1b2a1b2 00000000 10
0 2 0 0 00000500 00000000 3 1 11223344 f 00000000 11223344 22
1 2 0 0 00000504 cafef00d 2 1 00000000 f cafef00d 00000000 11
1 0 0 0 00000505 00000012 4 1 00000000 2 12121212 00000000 11
0 5 0 0 0000050a 00000000 2 1 9abc0000 c 00000000 00009abc 22

/* filelist.f */
hdl/lsu_pkg.sv
hdl/lsu_req_if.sv
hdl/lsu_pmp_check.sv
hdl/lsu_request.sv
hdl/lsu_access_arbiter.sv
hdl/lsu_load_align.sv
hdl/lsu_top.sv
verification/lsu_checker.sv
verification/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu_pmp

sources:
  - hdl/lsu_pkg.sv
  - hdl/lsu_req_if.sv
  - hdl/lsu_pmp_check.sv
  - hdl/lsu_request.sv
  - hdl/lsu_access_arbiter.sv
  - hdl/lsu_load_align.sv
  - hdl/lsu_top.sv
  - target: test
    files:
      - verification/lsu_checker.sv
      - verification/lsu_tb.sv
